/* include/alu_config.svh */
// Width macros shared by the ALU package and RTL
// Data word, opcode field and shift amount

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// **************************************************
// Data path
// **************************************************

// Operand and result width, one word
`define ALU_WIDTH 32

// **************************************************
// Instruction fields
// **************************************************

// Opcode field width, 64 codes
`define ALU_OP_WIDTH 6

// Low acc bits used as shift amount
// Must cover log2 of ALU_WIDTH
`define ALU_SHAMT_WIDTH 5

`endif

/* project.f */
+incdir+include
source/alu_pkg.sv
source/alu_pipe_stage.sv
source/alu_arith.sv
source/alu_bitwise.sv
source/alu_cond.sv
source/alu_result_mux.sv
source/alu_top.sv
tb/alu_chk.sv
tb/alu_tb.sv

/* source/alu_arith.sv */
// Arithmetic group: ADD, MLT, SGN, NEG, ABS, PST
// Combinational, zero for opcodes of other groups

`include "alu_config.svh"

module alu_arith (
	input  alu_pkg::alu_op_t   op,      // Opcode of the registered request
	input  alu_pkg::alu_word_t mem,     // Memory operand
	input  alu_pkg::alu_word_t acc,     // Accumulator operand
	output alu_pkg::alu_word_t result
);
	import alu_pkg::*;

	logic      mem_neg;   // Sign bit of mem
	logic      acc_neg;   // Sign bit of acc
	alu_word_t acc_minus; // Two's complement of acc
	alu_word_t sum;
	alu_word_t product;

	assign mem_neg   = mem[`ALU_WIDTH-1];
	assign acc_neg   = acc[`ALU_WIDTH-1];
	assign acc_minus = -acc;            // Shared by SGN, NEG and ABS

	assign sum     = mem + acc;         // Wraps modulo 2^32
	assign product = mem * acc;         // Upper word dropped

	// **************************************************
	// Opcode decode
	// **************************************************

	always_comb begin
		case (op)
			OP_ADD: result = sum;
			OP_MLT: result = product;
			// Sign of mem copied onto acc
			OP_SGN: result = (mem_neg == acc_neg) ? acc : acc_minus;
			OP_NEG: result = acc_minus;
			OP_ABS: result = acc_neg ? acc_minus : acc;  // Most negative stays
			OP_PST: result = acc_neg ? '0 : acc;
			default: begin
				result = '0;  // Not ours
			end
		endcase
	end

endmodule

/* source/alu_bitwise.sv */
// Bitwise and shift group: AND, ORR, XOR, INV, SHL, SHR, SRS
// Shift amount taken from the low acc bits

`include "alu_config.svh"

module alu_bitwise (
	input  alu_pkg::alu_op_t   op,      // Opcode of the registered request
	input  alu_pkg::alu_word_t mem,     // Memory operand, shifted value
	input  alu_pkg::alu_word_t acc,     // Accumulator operand, shift amount
	output alu_pkg::alu_word_t result
);
	import alu_pkg::*;

	logic [`ALU_SHAMT_WIDTH-1:0] shamt;  // Upper acc bits ignored
	alu_word_t                   shl_res;
	alu_word_t                   shr_res;
	alu_word_t                   srs_res;

	assign shamt = acc[`ALU_SHAMT_WIDTH-1:0];

	// **************************************************
	// Shifters
	// **************************************************

	assign shl_res = mem << shamt;
	assign shr_res = mem >> shamt;   // Zero fill
	assign srs_res = mem >>> shamt;  // Sign fill, mem is signed

	// Logic operations and shift select
	always_comb begin
		case (op)
			OP_AND: result = mem & acc;
			OP_ORR: result = mem | acc;
			OP_XOR: result = mem ^ acc;
			OP_INV: result = ~acc;       // One operand, acc only

			// Shifts of mem
			OP_SHL: result = shl_res;
			OP_SHR: result = shr_res;
			OP_SRS: result = srs_res;

			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* source/alu_cond.sv */
// Condition and comparison group: LAN, LOR, LIN, LES, GRE, EQU
// Each result is the word 1 or the word 0

module alu_cond (
	input  alu_pkg::alu_op_t   op,      // Opcode of the registered request
	input  alu_pkg::alu_word_t mem,     // Memory operand
	input  alu_pkg::alu_word_t acc,     // Accumulator operand
	output alu_pkg::alu_word_t result
);
	import alu_pkg::*;

	logic mem_true;  // mem non-zero
	logic acc_true;  // acc non-zero
	logic less;      // Signed mem < acc
	logic greater;   // Signed mem > acc
	logic equal;
	logic hit;       // Selected condition

	// **************************************************
	// Condition terms
	// **************************************************

	assign mem_true = (mem != '0);
	assign acc_true = (acc != '0);

	// Both operands are signed words, so compares are signed
	assign less    = (mem < acc);
	assign greater = (mem > acc);
	assign equal   = (mem == acc);

	// Pick the condition of this opcode
	always_comb begin
		case (op)
			OP_LAN: hit = mem_true && acc_true;
			OP_LOR: hit = mem_true || acc_true;
			OP_LIN: hit = !acc_true;        // acc only
			OP_LES: hit = less;
			OP_GRE: hit = greater;
			OP_EQU: hit = equal;
			default: begin
				hit = 1'b0;  // Gives word 0 outside the group
			end
		endcase
	end

	// Zero-extend the flag to a full word
	assign result = alu_word_t'({1'b0, hit});

endmodule

/* source/alu_pipe_stage.sv */
// Single-entry valid/ready register stage
// Payload type set by parameter

module alu_pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	// Upstream side
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	// Downstream side
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	// **************************************************
	// Storage
	// **************************************************

	logic     full;    // Entry holds a valid payload
	payload_t data_q;  // Payload register, no reset

	// Free slot, or the current entry leaves this edge
	assign in_ready = !full || out_ready;

	// Valid bit follows the upstream handshake
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			full <= 1'b0;
		end else if (in_ready) begin
			full <= in_valid;  // Load new entry or drain
		end
	end

	// Capture only on a real transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = full;
	assign out_data  = data_q;  // Held while stalled

endmodule

/* source/alu_pkg.sv */
// ALU types: data word, opcode enum and request payload
// Opcode numbers follow the accumulator processor ISA

`include "alu_config.svh"

package alu_pkg;

	// Signed data word, both operands and the result
	typedef logic signed [`ALU_WIDTH-1:0] alu_word_t;

	// **************************************************
	// Opcodes, integer subset only
	// **************************************************
	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		OP_NOP = 6'd0,   // Pass acc
		OP_LOD = 6'd1,   // Pass mem
		OP_ADD = 6'd2,
		OP_MLT = 6'd4,   // Low word of product
		OP_SGN = 6'd9,   // Sign of mem onto acc
		OP_NEG = 6'd11,
		OP_ABS = 6'd15,
		OP_PST = 6'd19,  // Clamp negatives to zero
		OP_AND = 6'd29,
		OP_ORR = 6'd30,
		OP_XOR = 6'd31,
		OP_INV = 6'd32,
		OP_LAN = 6'd34,  // Logical and
		OP_LOR = 6'd35,  // Logical or
		OP_LIN = 6'd36,  // Logical not of acc
		OP_LES = 6'd38,  // mem < acc, signed
		OP_GRE = 6'd40,  // mem > acc, signed
		OP_EQU = 6'd42,
		OP_SHL = 6'd43,
		OP_SHR = 6'd44,  // Logical right
		OP_SRS = 6'd45   // Arithmetic right
	} alu_op_t;

	// Request as it travels through the input stage
	typedef struct packed {
		alu_op_t   op;
		alu_word_t mem;  // Memory operand
		alu_word_t acc;  // Accumulator operand
	} alu_req_t;

endpackage

/* source/alu_result_mux.sv */
// Result select by opcode
// Owns the opcode to group mapping, pass-through and illegal codes

module alu_result_mux (
	input  alu_pkg::alu_op_t   op,
	input  alu_pkg::alu_word_t mem,             // For LOD
	input  alu_pkg::alu_word_t acc,             // For NOP
	input  alu_pkg::alu_word_t arith_result,
	input  alu_pkg::alu_word_t bitwise_result,
	input  alu_pkg::alu_word_t cond_result,
	output alu_pkg::alu_word_t result
);
	import alu_pkg::*;

	// **************************************************
	// Group select
	// **************************************************

	always_comb begin
		case (op)
			// Pass-through
			OP_NOP: result = acc;
			OP_LOD: result = mem;

			// Arithmetic group
			OP_ADD,
			OP_MLT,
			OP_SGN,
			OP_NEG,
			OP_ABS,
			OP_PST: result = arith_result;

			// Bitwise and shift group
			OP_AND,
			OP_ORR,
			OP_XOR,
			OP_INV,
			OP_SHL,
			OP_SHR,
			OP_SRS: result = bitwise_result;

			// Conditions and compares
			OP_LAN,
			OP_LOR,
			OP_LIN,
			OP_LES,
			OP_GRE,
			OP_EQU: result = cond_result;

			// Float, divide and _M codes are not built
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* source/alu_top.sv */
// Pipelined integer ALU, top level
// Request stage, three operation groups, result mux, result stage
// Two edges from accepted request to out_valid

module alu_top (
	input  logic               clk,
	input  logic               arst_n,
	// Request side
	input  logic               in_valid,
	input  alu_pkg::alu_op_t   in_op,
	input  alu_pkg::alu_word_t in_mem,
	input  alu_pkg::alu_word_t in_acc,
	output logic               in_ready,
	// Result side
	output logic               out_valid,
	output alu_pkg::alu_word_t out_result,
	input  logic               out_ready
);
	import alu_pkg::*;

	alu_req_t  req_in;          // Packed input request
	alu_req_t  req;             // Registered request
	logic      req_valid;
	logic      res_ready;       // Result stage can take a word
	alu_word_t arith_result;
	alu_word_t bitwise_result;
	alu_word_t cond_result;
	alu_word_t mux_result;      // Word chosen for this opcode

	assign req_in = '{op: in_op, mem: in_mem, acc: in_acc};

	// **************************************************
	// Stage 1, request register
	// **************************************************

	alu_pipe_stage #(.payload_t(alu_req_t)) u_req_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_data   (req_in),
		.in_ready  (in_ready),
		.out_valid (req_valid),
		.out_data  (req),
		.out_ready (res_ready)   // Stalls when result stage is blocked
	);

	// **************************************************
	// Operation groups, combinational
	// **************************************************

	alu_arith u_arith (
		.op     (req.op),
		.mem    (req.mem),
		.acc    (req.acc),
		.result (arith_result)
	);

	alu_bitwise u_bitwise (
		.op     (req.op),
		.mem    (req.mem),
		.acc    (req.acc),
		.result (bitwise_result)
	);

	alu_cond u_cond (
		.op     (req.op),
		.mem    (req.mem),
		.acc    (req.acc),
		.result (cond_result)
	);

	alu_result_mux u_mux (
		.op             (req.op),
		.mem            (req.mem),
		.acc            (req.acc),
		.arith_result   (arith_result),
		.bitwise_result (bitwise_result),
		.cond_result    (cond_result),
		.result         (mux_result)
	);

	// Stage 2, result register
	alu_pipe_stage #(.payload_t(alu_word_t)) u_res_stage (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (req_valid),
		.in_data   (mux_result),
		.in_ready  (res_ready),
		.out_valid (out_valid),
		.out_data  (out_result),
		.out_ready (out_ready)
	);

endmodule

/* tb/alu_chk.sv */
// Bound assertions on the ALU result handshake
// Reset idle, hold under stall, known result word

module alu_chk (
	input logic               clk,
	input logic               arst_n,
	input logic               out_valid,
	input logic               out_ready,
	input alu_pkg::alu_word_t out_result
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;  // Assertion failures so far

	// No result while reset is held
	a_reset_idle: assert property (@(posedge clk) !arst_n |-> !out_valid)
		else begin
			$error("out_valid high while arst_n is low");
			fail_count++;
		end

	// Stalled result keeps valid and data
	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
		else begin
			$error("result dropped or changed while stalled");
			fail_count++;
		end

	a_known_result: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !$isunknown(out_result))
		else begin
			$error("out_result unknown while out_valid is high");
			fail_count++;
		end

endmodule

bind alu_top alu_chk u_chk (
	.clk        (clk),
	.arst_n     (arst_n),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_result (out_result)
);

/* tb/alu_tb.sv */
// Table-driven testbench for the pipelined ALU
// Random result back-pressure, expected words kept in a queue

module alu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import alu_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	// Request plus hand-computed result
	typedef struct packed {
		alu_req_t  req;
		alu_word_t result;
	} row_t;

	logic        clk;
	logic        arst_n;
	logic        in_valid;
	alu_op_t     in_op;
	alu_word_t   in_mem;
	alu_word_t   in_acc;
	logic        in_ready;
	logic        out_valid;
	alu_word_t   out_result;
	logic        out_ready;
	row_t        rows[$];
	alu_word_t   exp_q[$];    // Expected words, oldest first
	int          sent;
	int          received;
	logic        bp_enable;   // Random out_ready when set
	logic [31:0] rng_state;

	alu_top u_dut (.*);

	always #5 clk = ~clk;  // 10 ns period

	// **************************************************
	// Helpers
	// **************************************************

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input alu_word_t got, input alu_word_t exp_word);
		if (got !== exp_word) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
				$time, name, got, exp_word));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp_n);
		if (got != exp_n) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
				$time, name, got, exp_n));
		end
	endtask

	task automatic add_row(input alu_op_t op, input alu_word_t mem, input alu_word_t acc,
		input alu_word_t result);
		row_t r;
		r.req.op  = op;
		r.req.mem = mem;
		r.req.acc = acc;
		r.result  = result;
		rows.push_back(r);
	endtask

	// Called on a rising edge, returns on the accepting edge
	task automatic send_request(input row_t r);
		int waited;
		waited = 0;
		in_valid <= 1'b1;
		in_op    <= r.req.op;
		in_mem   <= r.req.mem;
		in_acc   <= r.req.acc;
		@(posedge clk);
		while (!in_ready) begin
			if (waited > TIMEOUT_CYCLES) report_failure("in_ready stayed low, request not taken");
			else begin
				@(posedge clk);
				waited++;
			end
		end
		exp_q.push_back(r.result);
		sent++;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited > TIMEOUT_CYCLES) report_failure("results did not drain in time");
			else begin
				@(negedge clk);  // Away from the monitor edge
				waited++;
			end
		end
	endtask

	// **************************************************
	// Stimulus table, results worked out by hand
	// **************************************************

	task automatic build_table();
		add_row(OP_ADD, 32'hFFFF_FFFE, 32'h0000_0003, 32'h0000_0001);  // Wraps
		add_row(OP_MLT, 32'h0001_0003, 32'h0001_0005, 32'h0008_000F);  // Low word
		add_row(OP_SGN, 32'h0000_0005, 32'h0000_0007, 32'h0000_0007);
		add_row(OP_SGN, 32'hFFFF_FFFF, 32'h0000_0007, 32'hFFFF_FFF9);
		add_row(OP_NEG, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF);
		add_row(OP_ABS, 32'h0000_0000, 32'hFFFF_FFEC, 32'h0000_0014);  // -20
		add_row(OP_PST, 32'h0000_0000, 32'hFFFF_FFFB, 32'h0000_0000);
		add_row(OP_PST, 32'h0000_0000, 32'h0000_0123, 32'h0000_0123);
		add_row(OP_AND, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000);
		add_row(OP_ORR, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hFFF0_FFF0);
		add_row(OP_XOR, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0FF0_0FF0);
		add_row(OP_INV, 32'h1234_5678, 32'h0000_FFFF, 32'hFFFF_0000);
		add_row(OP_SHL, 32'h0000_0001, 32'h0000_0004, 32'h0000_0010);
		add_row(OP_SHR, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
		add_row(OP_SRS, 32'h8000_0000, 32'h0000_0004, 32'hF800_0000);
		add_row(OP_SHL, 32'h0000_0001, 32'hFFFF_FFE3, 32'h0000_0008);  // Amount 3
		add_row(OP_LAN, 32'h0000_0005, 32'h0000_0003, 32'h0000_0001);
		add_row(OP_LAN, 32'h0000_0005, 32'h0000_0000, 32'h0000_0000);
		add_row(OP_LOR, 32'h0000_0000, 32'h0000_0009, 32'h0000_0001);
		add_row(OP_LIN, 32'h0000_0007, 32'h0000_0000, 32'h0000_0001);
		add_row(OP_LES, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);  // -1 < 1
		add_row(OP_GRE, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
		add_row(OP_EQU, 32'h0000_002A, 32'h0000_002A, 32'h0000_0001);
		add_row(OP_NOP, 32'h0000_0001, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
		add_row(OP_LOD, 32'hCAFE_F00D, 32'h0000_0001, 32'hCAFE_F00D);
		add_row(alu_op_t'(6'd3), 32'h0000_0005, 32'h0000_0006, 32'h0000_0000);
		add_row(alu_op_t'(6'd63), 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
	endtask

	// Output side, result compare and out_ready
	always @(posedge clk) begin
		if (arst_n && out_valid && out_ready) begin
			received++;  // Every output transfer, stray ones too
			if (exp_q.size() != 0) begin
				check_word("out_result", out_result, exp_q.pop_front());
			end
		end
		if (bp_enable) begin
			rng_state = xorshift(rng_state);
			out_ready <= rng_state[0];
		end else begin
			out_ready <= 1'b1;
		end
	end

	initial begin
		int lat;
		clk       = 1'b0;
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		in_op     = OP_NOP;
		in_mem    = '0;
		in_acc    = '0;
		out_ready = 1'b0;
		bp_enable = 1'b0;
		rng_state = 32'h6ef2_086f;
		sent      = 0;
		received  = 0;
		build_table();
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		// Single request with out_ready high, edges until out_valid
		@(posedge clk);
		send_request(rows[0]);
		in_valid <= 1'b0;
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!out_valid && lat < TIMEOUT_CYCLES);
		if (!out_valid) report_failure("no out_valid after a single accepted request");
		else check_count("out_valid latency", lat, 2);
		wait_drain();

		// Whole table back to back, random back-pressure
		@(posedge clk);
		bp_enable <= 1'b1;
		foreach (rows[i]) begin
			send_request(rows[i]);
		end
		in_valid <= 1'b0;
		wait_drain();

		// Two-deep pipeline, a stray result leaves within a few edges
		bp_enable <= 1'b0;
		repeat (4) @(posedge clk);
		check_count("result count", received, sent);

		if (u_dut.u_chk.fail_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			report_failure($sformatf("%0d bound assertion failures", u_dut.u_chk.fail_count));
		end
	end

endmodule
